//--- Bender.yml
package:
  name: vector_unit

sources:
  - verilog/vector_isa_pkg.sv
  - verilog/vector_unit_pkg.sv
  - verilog/vector_csr.sv
  - verilog/vector_sequencer.sv
  - verilog/vector_alu.sv
  - verilog/vector_byte_enable.sv
  - verilog/vector_regbank.sv
  - verilog/vector_unit.sv
  - target: test
    files:
      - testbench/vector_unit_properties.sv
      - testbench/vector_unit_checker.sv
      - testbench/vector_unit_tb.sv

//--- files.f
verilog/vector_isa_pkg.sv
verilog/vector_unit_pkg.sv
verilog/vector_csr.sv
verilog/vector_sequencer.sv
verilog/vector_alu.sv
verilog/vector_byte_enable.sv
verilog/vector_regbank.sv
verilog/vector_unit.sv
testbench/vector_unit_properties.sv
testbench/vector_unit_checker.sv
testbench/vector_unit_tb.sv

//--- testbench/vector_unit_checker.sv
module vector_unit_checker (
    input logic        hold_i,
    input logic        wr_en_scalar_i,
    input logic [31:0] res_scalar_i,
    input logic [31:0] vtype_i,
    input logic [31:0] vlen_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int error_count  = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("error t=%0t %s expected %h got %h", $time, name, expected, actual);
        error_count++;
        test_errors++;
    endtask

    // Sampled mid-cycle, once hold_o has dropped
    task automatic check_scalar(input bit check_res, input logic [31:0] expected,
                                input bit expected_wr);
        if (wr_en_scalar_i !== expected_wr) begin
            report_value("wr_en_scalar_o", 32'(expected_wr), 32'(wr_en_scalar_i));
        end
        if (check_res && res_scalar_i !== expected) begin
            report_value("res_scalar_o", expected, res_scalar_i);
        end
    endtask

    task automatic check_csr(input logic [31:0] expected_vl, input logic [31:0] expected_vtype);
        if (vlen_i !== expected_vl) begin
            report_value("vlen_o", expected_vl, vlen_i);
        end
        if (vtype_i !== expected_vtype) begin
            report_value("vtype_o", expected_vtype, vtype_i);
        end
    endtask

    task automatic check_reset();
        check_scalar(1'b0, '0, 1'b0);
        check_csr('0, '0);
        if (hold_i !== 1'b0) begin
            report_value("hold_o", 32'd0, 32'(hold_i));
        end
    endtask

    task automatic end_test(input int index, input string label, input int expected_hold,
                            input int seen_hold);
        if (expected_hold >= 0 && expected_hold != seen_hold) begin
            $display("hold_o stayed high for %0d cycles instead of %0d in test %0d",
                     seen_hold, expected_hold, index);
            error_count++;
            test_errors++;
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", index, label);
        end else begin
            $display("test %0d %s: FAILED", index, label);
            tests_failed++;
        end
        test_errors = 0;
    endtask

endmodule

//--- testbench/vector_unit_properties.sv
module vector_unit_properties (
    input logic clk,
    input logic reset_n,
    input logic hold_i,
    input logic wr_en_scalar_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // First cycle out of reset starts idle
    assert property (@(posedge clk) $rose(reset_n) |-> !hold_i)
        else $error("hold_o high in first cycle after reset");

    assert property (@(posedge clk) disable iff (!reset_n) !(hold_i && wr_en_scalar_i))
        else $error("hold_o and wr_en_scalar_o high together");

    // Longest group is 8 registers plus the END cycle
    assert property (@(posedge clk) disable iff (!reset_n) $rose(hold_i) |-> ##[1:9] !hold_i)
        else $error("hold_o high for more than 9 cycles");

endmodule

bind vector_unit vector_unit_properties u_properties (
    .clk            (clk),
    .reset_n        (reset_n),
    .hold_i         (hold_o),
    .wr_en_scalar_i (wr_en_scalar_o)
);

//--- testbench/vector_unit_tb.sv
module vector_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vector_isa_pkg::*;

    localparam int VLEN    = 64;
    localparam int VLENB   = VLEN / 8;
    localparam int TIMEOUT = 20;

    typedef struct {
        vector_op_e  op;
        logic [31:0] instr;
        logic [31:0] scalar;
        logic [31:0] exp_res;
        bit          chk_res;
        int          exp_hold;
        bit          chk_csr;
        logic [31:0] exp_vl;
        logic [31:0] exp_vtype;
        string       label;
    } row_t;

    logic        clk;
    logic        reset_n;
    logic [31:0] instruction;
    vector_op_e  vector_operation;
    logic [31:0] op1_scalar;
    logic        hold;
    logic [31:0] vtype;
    logic [31:0] vlen;
    logic [31:0] res_scalar;
    logic        wr_en_scalar;

    row_t table_q[$];
    int   hold_count;

    vector_unit #(.VLEN(VLEN)) dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .instruction_i      (instruction),
        .vector_operation_i (vector_operation),
        .op1_scalar_i       (op1_scalar),
        .hold_o             (hold),
        .vtype_o            (vtype),
        .vlen_o             (vlen),
        .res_scalar_o       (res_scalar),
        .wr_en_scalar_o     (wr_en_scalar)
    );

    vector_unit_checker u_checker (
        .hold_i         (hold),
        .wr_en_scalar_i (wr_en_scalar),
        .res_scalar_i   (res_scalar),
        .vtype_i        (vtype),
        .vlen_i         (vlen)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Encoding and expected values
    ////////////////////////////////////////////////////////////

    function automatic int vlmax_of(input int sew, input int lmul);
        return (VLENB / (1 << sew)) * (1 << lmul);
    endfunction

    function automatic logic [31:0] enc_vsetvli(input int rs1, input int sew, input int lmul);
        logic [10:0] zimm;
        zimm = 11'((sew << 3) | lmul);
        return {1'b0, zimm, 5'(rs1), 3'b111, 5'd0, 7'h57};
    endfunction

    function automatic logic [31:0] enc_vop(input logic [2:0] funct3, input bit vm,
                                            input int vs2, input int vs1, input int vd);
        return {6'b0, vm, 5'(vs2), 5'(vs1), funct3, 5'(vd), 7'h57};
    endfunction

    // Each byte on its own with 8-bit wrap
    function automatic logic [31:0] byte_op(input vector_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] r;
        logic [7:0]  x;
        logic [7:0]  y;
        for (int i = 0; i < 4; i++) begin
            x = a[8*i +: 8];
            y = b[8*i +: 8];
            case (op)
                VADD:    r[8*i +: 8] = x + y;
                VSUB:    r[8*i +: 8] = x - y;
                VAND:    r[8*i +: 8] = x & y;
                VOR:     r[8*i +: 8] = x | y;
                default: r[8*i +: 8] = x ^ y;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] enable);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = enable[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////

    task automatic add_row(input vector_op_e op, input logic [31:0] instr,
                           input logic [31:0] scalar, input logic [31:0] exp_res,
                           input bit chk_res, input int exp_hold, input bit chk_csr,
                           input logic [31:0] exp_vl, input logic [31:0] exp_vtype,
                           input string label);
        row_t r;
        r.op        = op;
        r.instr     = instr;
        r.scalar    = scalar;
        r.exp_res   = exp_res;
        r.chk_res   = chk_res;
        r.exp_hold  = exp_hold;
        r.chk_csr   = chk_csr;
        r.exp_vl    = exp_vl;
        r.exp_vtype = exp_vtype;
        r.label     = label;
        table_q.push_back(r);
    endtask

    task automatic vsetvli_row(input int rs1, input int sew, input int lmul,
                               input int avl, input string label);
        int vlmax;
        int expected;
        vlmax = vlmax_of(sew, lmul);
        if (rs1 == 0) begin
            expected = vlmax;
        end else begin
            expected = (avl < vlmax) ? avl : vlmax;
        end
        add_row(VSETVLI, enc_vsetvli(rs1, sew, lmul), avl, expected, 1'b1, 0, 1'b1,
                expected, (sew << 3) | lmul, label);
    endtask

    task automatic seed(input int vd, input logic [31:0] value);
        add_row(VMVSX, enc_vop(OPMVX, 1'b1, 0, 0, vd), value, '0, 1'b0, 2, 1'b0, '0, '0,
                "vmv.s.x");
    endtask

    task automatic read_back(input int vs2, input logic [31:0] expected);
        add_row(VMVXS, enc_vop(OPMVV, 1'b1, vs2, 0, 0), '0, expected, 1'b1, 0, 1'b0, '0, '0,
                "vmv.x.s");
    endtask

    // Run at the current vtype, then read vd back at SEW=32
    task automatic arith(input vector_op_e op, input logic [2:0] funct3, input bit vm,
                         input int vd, input int vs2, input int vs1, input logic [31:0] scalar,
                         input logic [31:0] a, input logic [31:0] b, input logic [31:0] old,
                         input logic [3:0] enable, input string label);
        add_row(op, enc_vop(funct3, vm, vs2, vs1, vd), scalar, '0, 1'b0, 2, 1'b0, '0, '0,
                label);
        vsetvli_row(0, 2, 0, 0, "vsetvli e32");
        read_back(vd, merge_bytes(old, byte_op(op, a, b), enable));
        vsetvli_row(0, 0, 0, 0, "vsetvli e8");
    endtask

    task automatic build_table();
        logic [31:0] mask;
        read_back(5, 32'h0);
        for (int sew = 0; sew < 3; sew++) begin
            for (int lmul = 0; lmul < 4; lmul++) begin
                vsetvli_row(1, sew, lmul, vlmax_of(sew, lmul) - 1, "vsetvli avl below");
                vsetvli_row(1, sew, lmul, vlmax_of(sew, lmul) + 5, "vsetvli avl above");
                vsetvli_row(0, sew, lmul, 3, "vsetvli rs1 x0");
            end
        end
        // Scalar round trip at each width
        for (int sew = 0; sew < 3; sew++) begin
            mask = (sew == 2) ? 32'hFFFF_FFFF : (32'h1 << (8 << sew)) - 1;
            vsetvli_row(0, sew, 0, 0, "vsetvli");
            seed(1, 32'hA5C3_96F1);
            read_back(1, 32'hA5C3_96F1 & mask);
        end
        vsetvli_row(0, 2, 0, 0, "vsetvli e32");
        seed(2, 32'h80FF_7F10);
        seed(3, 32'h0102_0304);
        seed(10, 32'hDEAD_BEEF);
        seed(11, 32'h1122_3344);
        seed(0, 32'h0000_00A5);
        vsetvli_row(0, 0, 0, 0, "vsetvli e8");
        arith(VADD, OPIVX, 1'b1, 4, 2, 0, 32'h81, 32'h80FF_7F10, 32'h8181_8181, '0, 4'hF,
              "vadd.vx");
        arith(VADD, OPIVI, 1'b1, 5, 2, 5'b11101, '0, 32'h80FF_7F10, 32'hFDFD_FDFD, '0, 4'hF,
              "vadd.vi");
        arith(VSUB, OPIVV, 1'b1, 6, 2, 3, '0, 32'h80FF_7F10, 32'h0102_0304, '0, 4'hF,
              "vsub.vv");
        arith(VAND, OPIVV, 1'b1, 7, 2, 3, '0, 32'h80FF_7F10, 32'h0102_0304, '0, 4'hF,
              "vand.vv");
        arith(VOR, OPIVX, 1'b1, 8, 2, 0, 32'h0F, 32'h80FF_7F10, 32'h0F0F_0F0F, '0, 4'hF,
              "vor.vx");
        arith(VXOR, OPIVI, 1'b1, 9, 2, 5'b01111, '0, 32'h80FF_7F10, 32'h0F0F_0F0F, '0, 4'hF,
              "vxor.vi");
        // v0 = 0xA5 enables bytes 0 and 2 of the low word
        arith(VADD, OPIVV, 1'b0, 10, 2, 3, '0, 32'h80FF_7F10, 32'h0102_0304, 32'hDEAD_BEEF,
              4'b0101, "vadd.vv masked");
        vsetvli_row(1, 0, 0, 2, "vsetvli vl=2");
        arith(VADD, OPIVX, 1'b1, 11, 2, 0, 32'h01, 32'h80FF_7F10, 32'h0101_0101, 32'h1122_3344,
              4'b0011, "vadd.vx tail");
        // Group of two registers
        vsetvli_row(0, 0, 1, 0, "vsetvli m2");
        add_row(VADD, enc_vop(OPIVX, 1'b1, 2, 0, 12), 32'h01, '0, 1'b0, 3, 1'b0, '0, '0,
                "vadd.vx m2");
        // Straight after the group walk, still at SEW=8
        read_back(12, byte_op(VADD, 32'h80FF_7F10, 32'h0101_0101) & 32'h0000_00FF);
        vsetvli_row(0, 2, 0, 0, "vsetvli e32");
        read_back(12, byte_op(VADD, 32'h80FF_7F10, 32'h0101_0101));
        read_back(13, byte_op(VADD, 32'h0102_0304, 32'h0101_0101));
    endtask

    ////////////////////////////////////////////////////////////
    // Apply
    ////////////////////////////////////////////////////////////

    initial begin
        reset_n          = 1'b0;
        instruction      = '0;
        vector_operation = VNOP;
        op1_scalar       = '0;
        build_table();
        repeat (8) @(posedge clk);
        #1 reset_n = 1'b1;
        @(posedge clk);
        #1;
        u_checker.check_reset();
        u_checker.end_test(0, "reset", -1, 0);
        foreach (table_q[i]) begin
            instruction      = table_q[i].instr;
            vector_operation = table_q[i].op;
            op1_scalar       = table_q[i].scalar;
            hold_count = 0;
            @(negedge clk);
            while (hold && hold_count < TIMEOUT) begin
                hold_count++;
                @(negedge clk);
            end
            if (hold) begin
                $display("timeout: hold_o did not fall within %0d cycles in test %0d",
                         TIMEOUT, i + 1);
                $display("Errors found");
                $finish;
            end else begin
                u_checker.check_scalar(table_q[i].chk_res, table_q[i].exp_res,
                                       table_q[i].op inside {VSETVLI, VMVXS});
                @(posedge clk);
                #1;
                if (table_q[i].chk_csr) begin
                    u_checker.check_csr(table_q[i].exp_vl, table_q[i].exp_vtype);
                end
                u_checker.end_test(i + 1, table_q[i].label, table_q[i].exp_hold, hold_count);
            end
        end
        vector_operation = VNOP;
        $display("tests %0d, failed %0d, errors %0d", u_checker.tests_run,
                 u_checker.tests_failed, u_checker.error_count);
        if (u_checker.error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog/vector_alu.sv
module vector_alu #(
    parameter int VLEN = 64
) (
    input  logic                       clk,
    input  vector_isa_pkg::vector_op_e vector_operation_i,
    input  vector_isa_pkg::op_cat_e    op_cat_i,
    input  vector_isa_pkg::vsew_e      vsew_i,
    input  logic [VLEN-1:0]            vs1_data_i,
    input  logic [VLEN-1:0]            vs2_data_i,
    input  logic [31:0]                scalar_i,
    input  logic [4:0]                 simm_i,
    input  logic                       exec_i,
    output logic [VLEN-1:0]            result_o
);

    import vector_isa_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [VLEN-1:0] scalar_rep;
    logic [VLEN-1:0] imm_rep;
    logic [VLEN-1:0] operand_b;
    logic [VLEN-1:0] operand_b_adj;
    logic [VLEN-1:0] sum;
    logic [VLEN-1:0] op_result;
    logic [1:0]      elem_mask;
    logic            is_sub;

    //////////////////////////////////////////////////////////////
    // Operands
    //////////////////////////////////////////////////////////////

    always_comb begin
        unique case (vsew_i)
            EW8: begin
                scalar_rep = {VLENB{scalar_i[7:0]}};
                imm_rep    = {VLENB{{3{simm_i[4]}}, simm_i}};
                elem_mask  = 2'b00;
            end
            EW16: begin
                scalar_rep = {(VLENB/2){scalar_i[15:0]}};
                imm_rep    = {(VLENB/2){{11{simm_i[4]}}, simm_i}};
                elem_mask  = 2'b01;
            end
            default: begin
                scalar_rep = {(VLENB/4){scalar_i}};
                imm_rep    = {(VLENB/4){{27{simm_i[4]}}, simm_i}};
                elem_mask  = 2'b11;
            end
        endcase
    end

    always_comb begin
        unique case (op_cat_i)
            OPIVX, OPMVX: operand_b = scalar_rep;
            OPIVI:        operand_b = imm_rep;
            default:      operand_b = vs1_data_i;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // Element operation
    //////////////////////////////////////////////////////////////

    // Subtract as vs2 + ~b + 1
    assign is_sub        = (vector_operation_i == VSUB);
    assign operand_b_adj = is_sub ? ~operand_b : operand_b;

    // Byte-wide adders, carry restarts at each element's low byte
    always_comb begin : byte_adder
        logic       carry;
        logic [8:0] byte_sum;
        carry = 1'b0;
        for (int i = 0; i < VLENB; i++) begin
            if ((2'(i) & elem_mask) == 2'b00) begin
                carry = is_sub;
            end
            byte_sum = {1'b0, vs2_data_i[8*i +: 8]} + {1'b0, operand_b_adj[8*i +: 8]}
                       + {8'b0, carry};
            sum[8*i +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    always_comb begin
        unique case (vector_operation_i)
            VADD, VSUB: op_result = sum;
            VAND:       op_result = vs2_data_i & operand_b;
            VOR:        op_result = vs2_data_i | operand_b;
            VXOR:       op_result = vs2_data_i ^ operand_b;
            VMVSX:      op_result = scalar_rep;
            default:    op_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_i) begin
            result_o <= op_result;
        end
    end

endmodule

//--- verilog/vector_byte_enable.sv
module vector_byte_enable #(
    parameter  int VLEN  = 64,
    localparam int VLENB = VLEN / 8,
    localparam int VL_W  = $clog2(VLEN + 1)
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  vector_isa_pkg::vector_op_e vector_operation_i,
    input  vector_isa_pkg::vsew_e      vsew_i,
    input  logic                       vm_i,
    input  logic [VLEN-1:0]            v0_i,
    input  logic [2:0]                 group_index_i,
    input  logic [VL_W-1:0]            vl_remaining_i,
    input  logic                       exec_i,
    input  logic [4:0]                 rd_i,
    output logic [VLENB-1:0]           write_enable_o,
    output logic [4:0]                 vd_addr_o
);

    import vector_isa_pkg::*;

    logic [VLENB-1:0] byte_en;
    logic [VL_W-1:0]  elems_per_reg;

    assign elems_per_reg = VL_W'(VLENB >> vsew_i);

    // Element of byte i is i >> sew, its mask bit sits after the
    // bits of the earlier registers in the group
    always_comb begin : enable_calc
        int elem;
        int mask_bit;
        for (int i = 0; i < VLENB; i++) begin
            elem     = i >> vsew_i;
            mask_bit = int'(group_index_i) * int'(elems_per_reg) + elem;
            if (vector_operation_i == VMVSX) begin
                byte_en[i] = (elem == 0);
            end else begin
                byte_en[i] = (vm_i || v0_i[mask_bit]) && (elem < int'(vl_remaining_i));
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= '0;
        end else if (exec_i) begin
            write_enable_o <= byte_en;
        end else begin
            write_enable_o <= '0;
        end
    end

    // Destination follows the group walk
    always_ff @(posedge clk) begin
        if (exec_i) begin
            vd_addr_o <= rd_i + {2'b00, group_index_i};
        end
    end

endmodule

//--- verilog/vector_csr.sv
module vector_csr #(
    parameter  int VLEN = 64,
    localparam int VL_W = $clog2(VLEN + 1)
) (
    input  logic                                  clk,
    input  logic                                  reset_n,
    input  vector_isa_pkg::vector_op_e            vector_operation_i,
    input  logic [31:0]                           avl_i,
    input  logic [vector_isa_pkg::ZIMM_W-1:0]     zimm_i,
    input  logic [4:0]                            rs1_i,
    output logic [31:0]                           vtype_o,
    output vector_isa_pkg::vsew_e                 vsew_o,
    output vector_isa_pkg::vlmul_e                vlmul_o,
    output logic [VL_W-1:0]                       vl_o,
    output logic [VL_W-1:0]                       vl_next_o
);

    import vector_isa_pkg::*;

    localparam int VLENB = VLEN / 8;

    logic [2:0]      zimm_sew;
    logic [2:0]      zimm_lmul;
    logic [VL_W-1:0] elems_per_reg;
    logic [VL_W-1:0] vlmax;

    //////////////////////////////////////////////////////////////
    // vsetvli length
    //////////////////////////////////////////////////////////////

    assign zimm_sew      = zimm_i[VTYPE_VSEW_LSB +: 3];
    assign zimm_lmul     = zimm_i[VTYPE_VLMUL_LSB +: 3];
    assign elems_per_reg = VL_W'(VLENB >> zimm_sew);
    assign vlmax         = elems_per_reg << zimm_lmul;

    // rs1 = x0 asks for the whole group
    always_comb begin
        if (rs1_i == 5'd0 || avl_i >= 32'(vlmax)) begin
            vl_next_o = vlmax;
        end else begin
            vl_next_o = avl_i[VL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vtype_o <= '0;
            vl_o    <= '0;
        end else if (vector_operation_i == VSETVLI) begin
            vtype_o <= {{(32 - ZIMM_W){1'b0}}, zimm_i};
            vl_o    <= vl_next_o;
        end
    end

    assign vsew_o  = vsew_e'(vtype_o[VTYPE_VSEW_LSB +: 3]);
    assign vlmul_o = vlmul_e'(vtype_o[VTYPE_VLMUL_LSB +: 3]);

endmodule

//--- verilog/vector_isa_pkg.sv
package vector_isa_pkg;

    // Decoded vector operation from the core
    typedef enum logic [3:0] {
        VNOP    = 4'd0,
        VSETVLI = 4'd1,
        VADD    = 4'd2,
        VSUB    = 4'd3,
        VAND    = 4'd4,
        VOR     = 4'd5,
        VXOR    = 4'd6,
        VMVSX   = 4'd7,
        VMVXS   = 4'd8
    } vector_op_e;

    // funct3 operand category
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPMVX = 3'b110
    } op_cat_e;

    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vsew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    // Instruction word fields
    localparam int REG_ADDR_W = 5;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int VM_POS     = 25;
    localparam int ZIMM_LSB   = 20;
    localparam int ZIMM_W     = 11;

    // vtype fields inside zimm
    localparam int VTYPE_VLMUL_LSB = 0;
    localparam int VTYPE_VSEW_LSB  = 3;

endpackage

//--- verilog/vector_regbank.sv
module vector_regbank #(
    parameter  int VLEN  = 64,
    localparam int VLENB = VLEN / 8
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic [4:0]       vs1_addr_i,
    input  logic [4:0]       vs2_addr_i,
    output logic [VLEN-1:0]  vs1_data_o,
    output logic [VLEN-1:0]  vs2_data_o,
    input  logic [VLENB-1:0] write_enable_i,
    input  logic [4:0]       vd_addr_i,
    input  logic [VLEN-1:0]  result_i,
    output logic [VLEN-1:0]  v0_o
);

    logic [VLEN-1:0] regs [32];

    // Byte-granular write into vd
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < VLENB; b++) begin
                if (write_enable_i[b]) begin
                    regs[vd_addr_i][8*b +: 8] <= result_i[8*b +: 8];
                end
            end
        end
    end

    assign vs1_data_o = regs[vs1_addr_i];
    assign vs2_data_o = regs[vs2_addr_i];
    assign v0_o       = regs[0];

endmodule

//--- verilog/vector_sequencer.sv
module vector_sequencer #(
    parameter  int VLEN = 64,
    localparam int VL_W = $clog2(VLEN + 1)
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  vector_isa_pkg::vector_op_e vector_operation_i,
    input  vector_isa_pkg::vsew_e      vsew_i,
    input  vector_isa_pkg::vlmul_e     vlmul_i,
    input  logic [VL_W-1:0]            vl_i,
    output logic                       hold_o,
    output logic                       exec_o,
    output logic [2:0]                 group_index_o,
    output logic [VL_W-1:0]            vl_remaining_o
);

    import vector_isa_pkg::*;
    import vector_unit_pkg::*;

    localparam int VLENB = VLEN / 8;

    vector_state_e   state, next_state;
    logic [2:0]      group_last;
    logic [VL_W-1:0] elems_per_reg;

    assign elems_per_reg = VL_W'(VLENB >> vsew_i);

    // Last register of the group
    // vmv.s.x touches one register only
    always_comb begin
        if (vector_operation_i == VMVSX) begin
            group_last = 3'd0;
        end else begin
            unique case (vlmul_i)
                LMUL_2:  group_last = 3'd1;
                LMUL_4:  group_last = 3'd3;
                LMUL_8:  group_last = 3'd7;
                default: group_last = 3'd0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////////////////

    always_comb begin
        unique case (state)
            V_IDLE: begin
                if (vector_operation_i inside {VADD, VSUB, VAND, VOR, VXOR, VMVSX}) begin
                    next_state = V_EXEC;
                end else begin
                    next_state = V_IDLE;
                end
            end
            V_EXEC:  next_state = (group_index_o == group_last) ? V_END : V_EXEC;
            default: next_state = V_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= V_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign hold_o = next_state inside {V_EXEC, V_END};
    assign exec_o = (state == V_EXEC);

    // Group index and elements still to go
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            group_index_o  <= '0;
            vl_remaining_o <= '0;
        end else if (state != V_EXEC) begin
            group_index_o  <= '0;
            vl_remaining_o <= vl_i;
        end else if (next_state == V_EXEC) begin
            group_index_o  <= group_index_o + 3'd1;
            vl_remaining_o <= (vl_remaining_o > elems_per_reg)
                              ? vl_remaining_o - elems_per_reg
                              : '0;
        end
    end

endmodule

//--- verilog/vector_unit.sv
module vector_unit #(
    parameter int VLEN = 64
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic [31:0]                instruction_i,
    input  vector_isa_pkg::vector_op_e vector_operation_i,
    input  logic [31:0]                op1_scalar_i,
    output logic                       hold_o,
    output logic [31:0]                vtype_o,
    output logic [31:0]                vlen_o,
    output logic [31:0]                res_scalar_o,
    output logic                       wr_en_scalar_o
);

    import vector_isa_pkg::*;

    localparam int VLENB = VLEN / 8;
    localparam int VL_W  = $clog2(VLEN + 1);

    logic [REG_ADDR_W-1:0] rd, rs1, rs2;
    logic [REG_ADDR_W-1:0] vs1_addr, vs2_addr, vd_addr;
    logic                  vm;
    logic [ZIMM_W-1:0]     zimm;
    op_cat_e               op_cat;

    vsew_e                 vsew;
    vlmul_e                vlmul;
    logic [VL_W-1:0]       vl, vl_next, vl_remaining;
    logic                  exec;
    logic [2:0]            group_index;

    logic [VLEN-1:0]       vs1_data, vs2_data, v0, result;
    logic [VLENB-1:0]      write_enable;

    //////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////

    assign rd     = instruction_i[RD_LSB  +: REG_ADDR_W];
    assign rs1    = instruction_i[RS1_LSB +: REG_ADDR_W];
    assign rs2    = instruction_i[RS2_LSB +: REG_ADDR_W];
    assign vm     = instruction_i[VM_POS];
    assign zimm   = instruction_i[ZIMM_LSB +: ZIMM_W];
    assign op_cat = op_cat_e'(instruction_i[FUNCT3_LSB +: 3]);

    // Sources step through the group with the sequencer
    assign vs1_addr = rs1 + {2'b00, group_index};
    assign vs2_addr = rs2 + {2'b00, group_index};

    assign vlen_o = 32'(vl);

    vector_csr #(.VLEN(VLEN)) u_csr (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .avl_i              (op1_scalar_i),
        .zimm_i             (zimm),
        .rs1_i              (rs1),
        .vtype_o            (vtype_o),
        .vsew_o             (vsew),
        .vlmul_o            (vlmul),
        .vl_o               (vl),
        .vl_next_o          (vl_next)
    );

    vector_sequencer #(.VLEN(VLEN)) u_sequencer (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .vsew_i             (vsew),
        .vlmul_i            (vlmul),
        .vl_i               (vl),
        .hold_o             (hold_o),
        .exec_o             (exec),
        .group_index_o      (group_index),
        .vl_remaining_o     (vl_remaining)
    );

    vector_alu #(.VLEN(VLEN)) u_alu (
        .clk                (clk),
        .vector_operation_i (vector_operation_i),
        .op_cat_i           (op_cat),
        .vsew_i             (vsew),
        .vs1_data_i         (vs1_data),
        .vs2_data_i         (vs2_data),
        .scalar_i           (op1_scalar_i),
        .simm_i             (rs1),
        .exec_i             (exec),
        .result_o           (result)
    );

    vector_byte_enable #(.VLEN(VLEN)) u_byte_enable (
        .clk                (clk),
        .reset_n            (reset_n),
        .vector_operation_i (vector_operation_i),
        .vsew_i             (vsew),
        .vm_i               (vm),
        .v0_i               (v0),
        .group_index_i      (group_index),
        .vl_remaining_i     (vl_remaining),
        .exec_i             (exec),
        .rd_i               (rd),
        .write_enable_o     (write_enable),
        .vd_addr_o          (vd_addr)
    );

    vector_regbank #(.VLEN(VLEN)) u_regbank (
        .clk            (clk),
        .reset_n        (reset_n),
        .vs1_addr_i     (vs1_addr),
        .vs2_addr_i     (vs2_addr),
        .vs1_data_o     (vs1_data),
        .vs2_data_o     (vs2_data),
        .write_enable_i (write_enable),
        .vd_addr_i      (vd_addr),
        .result_i       (result),
        .v0_o           (v0)
    );

    //////////////////////////////////////////////////////////////
    // Scalar result
    //////////////////////////////////////////////////////////////

    // Element 0 of vs2 zero-extended for vmv.x.s
    always_comb begin
        res_scalar_o   = '0;
        wr_en_scalar_o = 1'b0;
        if (vector_operation_i == VSETVLI) begin
            res_scalar_o   = 32'(vl_next);
            wr_en_scalar_o = 1'b1;
        end else if (vector_operation_i == VMVXS) begin
            unique case (vsew)
                EW8:     res_scalar_o = {24'b0, vs2_data[7:0]};
                EW16:    res_scalar_o = {16'b0, vs2_data[15:0]};
                default: res_scalar_o = vs2_data[31:0];
            endcase
            wr_en_scalar_o = 1'b1;
        end
    end

endmodule

//--- verilog/vector_unit_pkg.sv
package vector_unit_pkg;

    // Execution sequencer states
    typedef enum logic [1:0] {
        V_IDLE = 2'd0,
        V_EXEC = 2'd1,
        V_END  = 2'd2
    } vector_state_e;

endpackage
